// File: Makefile
TOP = tb_mem_subsys
LOG = run.log

all: run

build:
	verilator --binary --timing -j 0 -Wno-fatal --top-module $(TOP) -f filelist.f -o $(TOP)

run: build
	./obj_dir/$(TOP) | tee $(LOG)
	@grep -q "^TB PASSED$$" $(LOG) || (echo "Simulation failed, see $(LOG)"; exit 1)

lint:
	verilator --lint-only --timing -Wall --top-module $(TOP) -f filelist.f

clean:
	rm -rf obj_dir $(LOG)

.PHONY: all build run lint clean

// File: bench/sram_model.sv
`timescale 1ns/10ps

module sram_model (
	input  logic [sram_pkg::SRAM_ADDR_W-1:0] sram_addr,
	inout  wire  [sram_pkg::SRAM_DATA_W-1:0] sram_data,
	input  logic sram_en_n,
	input  logic sram_oe_n,
	input  logic sram_we_n
);

	localparam int WORDS = 1 << sram_pkg::SRAM_ADDR_W;

	logic [sram_pkg::SRAM_DATA_W-1:0] mem [WORDS];
	logic write_armed = 1'b0;

	// Preload, low address bits xor 5a5a
	initial begin
		for (int a = 0; a < WORDS; a++)
			mem[a] = 16'(a) ^ 16'h5a5a;
	end

	// Bus driven only while selected, output enabled and not writing
	assign sram_data = (!sram_en_n && !sram_oe_n && sram_we_n) ? mem[sram_addr] : 'z;

	// Write strobe starts with WE falling under enable
	always @(negedge sram_we_n) begin
		if (!sram_en_n)
			write_armed = 1'b1;
	end

	// Data latched as WE rises
	always @(posedge sram_we_n) begin
		if (write_armed) begin
			mem[sram_addr] = sram_data;
			write_armed = 1'b0;
		end
	end

endmodule

// File: bench/tb_mem_subsys.sv
`timescale 1ns/10ps

module tb_mem_subsys;

	localparam int CLK_NS = 4;
	localparam int WAIT_LIMIT = 200;
	localparam int LS_STORES = 8;
	localparam int SEQ_WORDS = 16;
	localparam int BP_WORDS = 24;
	localparam int RD_SEGMENTS = 6;
	localparam int RD_WORDS = 5;
	localparam int CT_WORDS = 24;
	localparam int CT_DATA = 9;
	// Every SRAM access of the run including discarded prefetches
	localparam int ACCESS_COUNT = LS_STORES * 3 + SEQ_WORDS + 1 + BP_WORDS + 1
		+ RD_SEGMENTS * (RD_WORDS + 1) + CT_WORDS + 1 + CT_DATA;
	localparam int WATCHDOG_NS = ACCESS_COUNT * 4 * (2 ** sram_pkg::RAM_DIV_BITS) * CLK_NS
		+ 20000;

	logic clk;
	logic rst;
	logic ls_valid;
	logic ls_ready;
	logic ls_write;
	logic [17:0] ls_addr;
	logic [15:0] ls_wdata;
	logic ls_resp_valid;
	logic [15:0] ls_rdata;
	logic redirect;
	logic [17:0] redirect_addr;
	logic inst_ready;
	logic inst_valid;
	logic [17:0] inst_addr;
	logic [15:0] inst_data;
	logic [17:0] sram_addr;
	wire  [15:0] sram_data;
	logic sram_en_n;
	logic sram_oe_n;
	logic sram_we_n;

	logic [15:0] shadow [1 << 18];
	int errors = 0;
	int tests_passed = 0;
	int tests_failed = 0;

	mem_subsys UUT (
		.clk(clk), .rst(rst),
		.ls_valid(ls_valid), .ls_ready(ls_ready), .ls_write(ls_write),
		.ls_addr(ls_addr), .ls_wdata(ls_wdata),
		.ls_resp_valid(ls_resp_valid), .ls_rdata(ls_rdata),
		.redirect(redirect), .redirect_addr(redirect_addr), .inst_ready(inst_ready),
		.inst_valid(inst_valid), .inst_addr(inst_addr), .inst_data(inst_data),
		.sram_addr(sram_addr), .sram_data(sram_data),
		.sram_en_n(sram_en_n), .sram_oe_n(sram_oe_n), .sram_we_n(sram_we_n)
	);

	sram_model u_sram (
		.sram_addr(sram_addr), .sram_data(sram_data),
		.sram_en_n(sram_en_n), .sram_oe_n(sram_oe_n), .sram_we_n(sram_we_n)
	);

	initial begin
		clk = 1'b0;
		forever #(CLK_NS / 2) clk = ~clk;
	end

	initial begin
		#(WATCHDOG_NS);
		$display("Timeout: the run did not finish within %0d ns", WATCHDOG_NS);
		$display("TB FAILED");
		$finish;
	end

	////////////////////////////////////////////////////////////////////////////
	// Helpers
	////////////////////////////////////////////////////////////////////////////

	function automatic logic [15:0] preload_word(input logic [17:0] a);
		return a[15:0] ^ 16'h5a5a;
	endfunction

	task automatic check_value(input logic [31:0] expected, input logic [31:0] actual,
		input string what);
		if (expected !== actual) begin
			$display("** Error at %0t ns: %s, expected %h, got %h", $time, what, expected,
				actual);
			errors++;
		end
	endtask

	task automatic report_test(input string name, input int start_errors);
		if (errors == start_errors) begin
			$display("%s: passed", name);
			tests_passed++;
		end else begin
			$display("%s: failed with %0d errors", name, errors - start_errors);
			tests_failed++;
		end
	endtask

	// One load or store started on a falling edge
	task automatic mem_access(input logic wr, input logic [17:0] addr,
		input logic [15:0] wdata);
		int waited;
		waited = 0;
		while (!ls_ready && waited < WAIT_LIMIT) begin
			@(negedge clk);
			waited++;
		end
		ls_valid = 1'b1;
		ls_write = wr;
		ls_addr = addr;
		ls_wdata = wdata;
		@(negedge clk);
		ls_valid = 1'b0;
		while (!ls_resp_valid && waited < WAIT_LIMIT) begin
			check_value(0, ls_ready, "ls_ready while request outstanding");
			// A write strobe can only belong to this store
			if (wr && !sram_we_n) begin
				check_value(addr, sram_addr, "SRAM address during write strobe");
				check_value(wdata, sram_data, "SRAM data during write strobe");
			end
			@(negedge clk);
			waited++;
		end
		if (!ls_resp_valid) begin
			$display("No load/store response for address %h within %0d cycles", addr,
				WAIT_LIMIT);
			errors++;
		end else if (wr)
			shadow[addr] = wdata;
		else
			check_value(shadow[addr], ls_rdata, "load data");
	endtask

	// Redirect, then take nwords with random stalls of up to stall_max cycles
	task automatic run_stream(input logic [17:0] start, input int nwords, input int stall_max);
		logic [17:0] expect_addr;
		logic held_valid;
		logic [17:0] held_addr;
		logic [15:0] held_data;
		int got;
		int idle;
		int stall;
		expect_addr = start;
		held_valid = 1'b0;
		got = 0;
		idle = 0;
		stall = 0;
		redirect = 1'b1;
		redirect_addr = start;
		inst_ready = 1'b0;
		@(negedge clk);
		redirect = 1'b0;
		while (got < nwords && idle < WAIT_LIMIT) begin
			if (held_valid) begin
				check_value(1, inst_valid, "inst_valid held while stalled");
				check_value(held_addr, inst_addr, "inst_addr held while stalled");
				check_value(held_data, inst_data, "inst_data held while stalled");
			end
			if (stall > 0) begin
				inst_ready = 1'b0;
				stall--;
			end else
				inst_ready = 1'b1;
			if (inst_valid && inst_ready) begin
				check_value(expect_addr, inst_addr, "fetched address");
				check_value(shadow[expect_addr], inst_data, "fetched word");
				expect_addr++;
				got++;
				idle = 0;
				stall = (stall_max > 0) ? int'($urandom_range(stall_max, 0)) : 0;
			end else
				idle++;
			held_valid = inst_valid && !inst_ready;
			held_addr = inst_addr;
			held_data = inst_data;
			@(negedge clk);
		end
		inst_ready = 1'b0;
		if (got < nwords) begin
			$display("Fetch stream from %h stopped after %0d of %0d words", start, got, nwords);
			errors++;
		end
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Directed tests
	////////////////////////////////////////////////////////////////////////////

	task automatic check_reset_state;
		int start_errors;
		start_errors = errors;
		// Fetch port must stay quiet with no redirect yet
		repeat (4) begin
			check_value(1, sram_en_n, "sram_en_n after reset");
			check_value(1, sram_oe_n, "sram_oe_n after reset");
			check_value(1, sram_we_n, "sram_we_n after reset");
			check_value(0, inst_valid, "inst_valid after reset");
			check_value(0, ls_resp_valid, "ls_resp_valid after reset");
			check_value(1, ls_ready, "ls_ready after reset");
			@(negedge clk);
		end
		report_test("reset state", start_errors);
	endtask

	task automatic load_store_sequence;
		logic [17:0] addrs [LS_STORES];
		logic [17:0] fresh;
		int start_errors;
		start_errors = errors;
		for (int i = 0; i < LS_STORES; i++) begin
			addrs[i] = {2'b01, 16'($urandom)};
			mem_access(1'b1, addrs[i], 16'($urandom));
		end
		for (int i = 0; i < LS_STORES; i++) begin
			mem_access(1'b0, addrs[i], 16'h0);
			fresh = {2'b11, 16'($urandom)};
			mem_access(1'b0, fresh, 16'h0);
			check_value(preload_word(fresh), ls_rdata, "untouched word");
		end
		report_test("loads and stores", start_errors);
	endtask

	task automatic sequential_fetch;
		int start_errors;
		start_errors = errors;
		run_stream({2'b00, 16'($urandom)}, SEQ_WORDS, 0);
		report_test("sequential fetch", start_errors);
	endtask

	task automatic fetch_back_pressure;
		int start_errors;
		start_errors = errors;
		run_stream({2'b00, 16'($urandom)}, BP_WORDS, 6);
		report_test("fetch back-pressure", start_errors);
	endtask

	task automatic redirect_mid_stream;
		int start_errors;
		int gap;
		start_errors = errors;
		for (int i = 0; i < RD_SEGMENTS; i++) begin
			run_stream({2'b00, 16'($urandom)}, RD_WORDS, 2);
			// First gap of 3 lands inside the next prefetch
			gap = (i == 0) ? 3 : int'($urandom_range(12, 0));
			repeat (gap) @(negedge clk);
		end
		report_test("redirect mid-stream", start_errors);
	endtask

	task automatic fetch_with_traffic;
		logic [17:0] start;
		logic [17:0] ahead;
		int start_errors;
		start_errors = errors;
		start = {2'b00, 16'($urandom)};
		ahead = start + 18'd20;
		fork
			run_stream(start, CT_WORDS, 2);
			begin
				repeat (2) @(negedge clk);
				mem_access(1'b1, ahead, ~preload_word(ahead));
				for (int i = 1; i < CT_DATA; i++)
					mem_access(1'($urandom), {2'b10, 16'($urandom)}, 16'($urandom));
			end
		join
		report_test("fetch with load/store traffic", start_errors);
	endtask

	initial begin
		void'($urandom(32'h069c_3638));
		rst = 1'b0;
		ls_valid = 1'b0;
		ls_write = 1'b0;
		ls_addr = '0;
		ls_wdata = '0;
		redirect = 1'b0;
		redirect_addr = '0;
		inst_ready = 1'b0;
		for (int a = 0; a < (1 << 18); a++)
			shadow[a] = preload_word(18'(a));
		repeat (4) @(negedge clk);
		rst = 1'b1;
		@(negedge clk);
		check_reset_state();
		load_store_sequence();
		sequential_fetch();
		fetch_back_pressure();
		redirect_mid_stream();
		fetch_with_traffic();
		$display("Tests passed: %0d, tests failed: %0d, check errors: %0d", tests_passed,
			tests_failed, errors);
		if (tests_failed == 0 && errors == 0)
			$display("TB PASSED");
		else
			$display("TB FAILED");
		$finish;
	end

endmodule

// File: filelist.f
verilog/sram_pkg.sv
verilog/fetch_port.sv
verilog/data_port.sv
verilog/sram_arbiter.sv
verilog/sram_ctrl.sv
verilog/mem_subsys.sv
bench/sram_model.sv
bench/tb_mem_subsys.sv

// File: verilog/data_port.sv
`timescale 1ns/10ps

module data_port (
	input  logic clk,
	input  logic rst,
	input  logic ls_valid,
	input  logic ls_write,
	input  logic [sram_pkg::SRAM_ADDR_W-1:0] ls_addr,
	input  logic [sram_pkg::SRAM_DATA_W-1:0] ls_wdata,
	output logic ls_ready,
	output logic ls_resp_valid,
	output logic [sram_pkg::SRAM_DATA_W-1:0] ls_rdata,
	output logic req,
	output logic req_write,
	output logic [sram_pkg::SRAM_ADDR_W-1:0] req_addr,
	output logic [sram_pkg::SRAM_DATA_W-1:0] req_wdata,
	input  logic ack,
	input  logic [sram_pkg::SRAM_DATA_W-1:0] rdata
);

	logic take;

	// Closed while a request is outstanding
	assign ls_ready = !req;
	assign take = ls_valid && ls_ready;

	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			req <= 1'b0;
			ls_resp_valid <= 1'b0;
		end else begin
			ls_resp_valid <= 1'b0;
			if (take) begin
				req <= 1'b1;
			end else if (ack) begin
				req <= 1'b0;
				ls_resp_valid <= 1'b1;
			end
		end
	end

	// Request fields held stable until the acknowledge
	always_ff @(posedge clk) begin
		if (take) begin
			req_write <= ls_write;
			req_addr <= ls_addr;
			req_wdata <= ls_wdata;
		end
		if (ack && !req_write)
			ls_rdata <= rdata;
	end

endmodule

// File: verilog/fetch_port.sv
`timescale 1ns/10ps

module fetch_port (
	input  logic clk,
	input  logic rst,
	input  logic redirect,
	input  logic [sram_pkg::SRAM_ADDR_W-1:0] redirect_addr,
	input  logic inst_ready,
	output logic inst_valid,
	output logic [sram_pkg::SRAM_ADDR_W-1:0] inst_addr,
	output logic [sram_pkg::SRAM_DATA_W-1:0] inst_data,
	output logic req,
	output logic [sram_pkg::SRAM_ADDR_W-1:0] req_addr,
	input  logic ack,
	input  logic [sram_pkg::SRAM_DATA_W-1:0] rdata
);

	logic active;
	logic discard;
	logic consume;
	logic issue;
	logic fill;
	logic [sram_pkg::SRAM_ADDR_W-1:0] next_addr;

	// The output registers are the one-word buffer
	assign consume = inst_valid && inst_ready;
	// Only one read at a time, and only into a free slot
	assign issue = active && !req && !redirect && (!inst_valid || consume);
	// A read that was overtaken by a redirect never reaches the buffer
	assign fill = req && ack && !discard && !redirect;

	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			active <= 1'b0;
			req <= 1'b0;
			discard <= 1'b0;
			inst_valid <= 1'b0;
		end else begin
			if (redirect) begin
				active <= 1'b1;
				inst_valid <= 1'b0;
				// Stale read still out, drop its result when it returns
				discard <= req && !ack;
			end else begin
				if (consume)
					inst_valid <= 1'b0;
				if (fill)
					inst_valid <= 1'b1;
				if (ack)
					discard <= 1'b0;
			end
			if (ack)
				req <= 1'b0;
			else if (issue)
				req <= 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (redirect)
			next_addr <= redirect_addr;
		else if (fill)
			next_addr <= req_addr + 1'b1;
		if (issue)
			req_addr <= next_addr;
		if (fill) begin
			inst_addr <= req_addr;
			inst_data <= rdata;
		end
	end

endmodule

// File: verilog/mem_subsys.sv
`timescale 1ns/10ps

module mem_subsys (
	input  logic clk,
	input  logic rst,
	// Load/store port
	input  logic ls_valid,
	output logic ls_ready,
	input  logic ls_write,
	input  logic [sram_pkg::SRAM_ADDR_W-1:0] ls_addr,
	input  logic [sram_pkg::SRAM_DATA_W-1:0] ls_wdata,
	output logic ls_resp_valid,
	output logic [sram_pkg::SRAM_DATA_W-1:0] ls_rdata,
	// Instruction fetch port
	input  logic redirect,
	input  logic [sram_pkg::SRAM_ADDR_W-1:0] redirect_addr,
	input  logic inst_ready,
	output logic inst_valid,
	output logic [sram_pkg::SRAM_ADDR_W-1:0] inst_addr,
	output logic [sram_pkg::SRAM_DATA_W-1:0] inst_data,
	// SRAM chip
	output logic [sram_pkg::SRAM_ADDR_W-1:0] sram_addr,
	inout  wire  [sram_pkg::SRAM_DATA_W-1:0] sram_data,
	output logic sram_en_n,
	output logic sram_oe_n,
	output logic sram_we_n
);

	logic fetch_req;
	logic fetch_ack;
	logic [sram_pkg::SRAM_ADDR_W-1:0] fetch_addr;
	logic [sram_pkg::SRAM_DATA_W-1:0] fetch_rdata;

	logic data_req;
	logic data_write;
	logic data_ack;
	logic [sram_pkg::SRAM_ADDR_W-1:0] data_addr;
	logic [sram_pkg::SRAM_DATA_W-1:0] data_wdata;
	logic [sram_pkg::SRAM_DATA_W-1:0] data_rdata;

	logic mem_req;
	logic mem_write;
	logic mem_ack;
	logic [sram_pkg::SRAM_ADDR_W-1:0] mem_addr;
	logic [sram_pkg::SRAM_DATA_W-1:0] mem_wdata;
	logic [sram_pkg::SRAM_DATA_W-1:0] mem_rdata;

	fetch_port u_fetch (
		.clk(clk), .rst(rst),
		.redirect(redirect), .redirect_addr(redirect_addr), .inst_ready(inst_ready),
		.inst_valid(inst_valid), .inst_addr(inst_addr), .inst_data(inst_data),
		.req(fetch_req), .req_addr(fetch_addr), .ack(fetch_ack), .rdata(fetch_rdata)
	);

	data_port u_data (
		.clk(clk), .rst(rst),
		.ls_valid(ls_valid), .ls_write(ls_write), .ls_addr(ls_addr), .ls_wdata(ls_wdata),
		.ls_ready(ls_ready), .ls_resp_valid(ls_resp_valid), .ls_rdata(ls_rdata),
		.req(data_req), .req_write(data_write), .req_addr(data_addr),
		.req_wdata(data_wdata), .ack(data_ack), .rdata(data_rdata)
	);

	sram_arbiter u_arb (
		.clk(clk), .rst(rst),
		.fetch_req(fetch_req), .fetch_addr(fetch_addr),
		.fetch_ack(fetch_ack), .fetch_rdata(fetch_rdata),
		.data_req(data_req), .data_write(data_write), .data_addr(data_addr),
		.data_wdata(data_wdata), .data_ack(data_ack), .data_rdata(data_rdata),
		.mem_req(mem_req), .mem_write(mem_write), .mem_addr(mem_addr),
		.mem_wdata(mem_wdata), .mem_ack(mem_ack), .mem_rdata(mem_rdata)
	);

	sram_ctrl u_ctrl (
		.clk(clk), .rst(rst),
		.mem_req(mem_req), .mem_write(mem_write), .mem_addr(mem_addr),
		.mem_wdata(mem_wdata), .mem_ack(mem_ack), .mem_rdata(mem_rdata),
		.sram_addr(sram_addr), .sram_data(sram_data),
		.sram_en_n(sram_en_n), .sram_oe_n(sram_oe_n), .sram_we_n(sram_we_n)
	);

endmodule

// File: verilog/sram_arbiter.sv
`timescale 1ns/10ps

module sram_arbiter (
	input  logic clk,
	input  logic rst,
	input  logic fetch_req,
	input  logic [sram_pkg::SRAM_ADDR_W-1:0] fetch_addr,
	output logic fetch_ack,
	output logic [sram_pkg::SRAM_DATA_W-1:0] fetch_rdata,
	input  logic data_req,
	input  logic data_write,
	input  logic [sram_pkg::SRAM_ADDR_W-1:0] data_addr,
	input  logic [sram_pkg::SRAM_DATA_W-1:0] data_wdata,
	output logic data_ack,
	output logic [sram_pkg::SRAM_DATA_W-1:0] data_rdata,
	output logic mem_req,
	output logic mem_write,
	output logic [sram_pkg::SRAM_ADDR_W-1:0] mem_addr,
	output logic [sram_pkg::SRAM_DATA_W-1:0] mem_wdata,
	input  logic mem_ack,
	input  logic [sram_pkg::SRAM_DATA_W-1:0] mem_rdata
);

	logic busy;
	// 1 when the data port holds the grant
	logic owner;
	logic sel;

	// Data port wins, but only while nobody holds the grant
	assign sel = busy ? owner : data_req;

	assign mem_req = sel ? data_req : fetch_req;
	assign mem_write = sel && data_write;
	assign mem_addr = sel ? data_addr : fetch_addr;
	assign mem_wdata = sel ? data_wdata : '0;

	assign data_ack = mem_ack && owner;
	assign fetch_ack = mem_ack && !owner;
	assign data_rdata = mem_rdata;
	assign fetch_rdata = mem_rdata;

	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			busy <= 1'b0;
			owner <= 1'b0;
		end else if (!busy && mem_req) begin
			busy <= 1'b1;
			owner <= sel;
		end else if (busy && mem_ack) begin
			busy <= 1'b0;
		end
	end

endmodule

// File: verilog/sram_ctrl.sv
`timescale 1ns/10ps

module sram_ctrl (
	input  logic clk,
	input  logic rst,
	input  logic mem_req,
	input  logic mem_write,
	input  logic [sram_pkg::SRAM_ADDR_W-1:0] mem_addr,
	input  logic [sram_pkg::SRAM_DATA_W-1:0] mem_wdata,
	output logic mem_ack,
	output logic [sram_pkg::SRAM_DATA_W-1:0] mem_rdata,
	output logic [sram_pkg::SRAM_ADDR_W-1:0] sram_addr,
	inout  wire  [sram_pkg::SRAM_DATA_W-1:0] sram_data,
	output logic sram_en_n,
	output logic sram_oe_n,
	output logic sram_we_n
);

	logic [sram_pkg::RAM_DIV_BITS-1:0] div;
	logic [sram_pkg::STATE_W-1:0] state;
	logic tick;
	logic accept;
	logic drive;
	logic [sram_pkg::SRAM_DATA_W-1:0] wdata_q;

	// Phases move on divider wrap only
	assign tick = (div == '0);
	// Requests are taken only in idle on a tick
	assign accept = tick && (state == sram_pkg::ST_IDLE) && mem_req;

	assign sram_data = drive ? wdata_q : {sram_pkg::SRAM_DATA_W{1'bz}};

	////////////////////////////////////////////////////////////////////////////
	// Phase sequencer
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			div <= '0;
			state <= sram_pkg::ST_IDLE;
			sram_en_n <= 1'b1;
			sram_oe_n <= 1'b1;
			sram_we_n <= 1'b1;
			drive <= 1'b0;
			mem_ack <= 1'b0;
		end else begin
			div <= div + 1'b1;
			mem_ack <= 1'b0;
			// Write data is held one cycle past the WE rising edge
			if (mem_ack)
				drive <= 1'b0;
			if (tick) begin
				case (state)
					sram_pkg::ST_IDLE: begin
						if (accept)
							state <= mem_write ? sram_pkg::ST_WR1 : sram_pkg::ST_RD1;
					end
					sram_pkg::ST_RD1: begin
						sram_en_n <= 1'b0;
						drive <= 1'b0;
						state <= sram_pkg::ST_RD2;
					end
					sram_pkg::ST_RD2: begin
						sram_oe_n <= 1'b0;
						state <= sram_pkg::ST_RD3;
					end
					sram_pkg::ST_RD3: begin
						sram_oe_n <= 1'b1;
						sram_en_n <= 1'b1;
						mem_ack <= 1'b1;
						state <= sram_pkg::ST_IDLE;
					end
					sram_pkg::ST_WR1: begin
						sram_en_n <= 1'b0;
						drive <= 1'b1;
						state <= sram_pkg::ST_WR2;
					end
					sram_pkg::ST_WR2: begin
						sram_we_n <= 1'b0;
						state <= sram_pkg::ST_WR3;
					end
					sram_pkg::ST_WR3: begin
						sram_we_n <= 1'b1;
						sram_en_n <= 1'b1;
						mem_ack <= 1'b1;
						state <= sram_pkg::ST_IDLE;
					end
					default: state <= sram_pkg::ST_IDLE;
				endcase
			end
		end
	end

	// Address and write data latched once
	// Read data taken in the last read phase
	always_ff @(posedge clk) begin
		if (accept) begin
			sram_addr <= mem_addr;
			wdata_q <= mem_wdata;
		end
		if (tick && state == sram_pkg::ST_RD3)
			mem_rdata <= sram_data;
	end

endmodule

// File: verilog/sram_pkg.sv
package sram_pkg;

	////////////////////////////////////////////////////////////////////////////
	// Bus widths shared by the requesters, the arbiter and the controller
	////////////////////////////////////////////////////////////////////////////

	// Word address on the SRAM chip
	localparam int SRAM_ADDR_W = 18;
	// One data word
	localparam int SRAM_DATA_W = 16;

	// Controller divider, a phase tick every 2**RAM_DIV_BITS cycles
	localparam int RAM_DIV_BITS = 1;

	// Controller state codes
	localparam int STATE_W = 3;
	localparam logic [STATE_W-1:0] ST_IDLE = 3'd0;
	localparam logic [STATE_W-1:0] ST_RD1 = 3'd1;
	localparam logic [STATE_W-1:0] ST_RD2 = 3'd2;
	localparam logic [STATE_W-1:0] ST_RD3 = 3'd3;
	localparam logic [STATE_W-1:0] ST_WR1 = 3'd5;
	localparam logic [STATE_W-1:0] ST_WR2 = 3'd6;
	localparam logic [STATE_W-1:0] ST_WR3 = 3'd7;

endpackage
